//--- vlog.f
+incdir+.
plic_pkg.sv
plic_gateway.sv
plic_regs.sv
plic_target.sv
periph_irq_top.sv
tb_periph_irq_top.sv

//--- tb_plic_model.svh
`ifndef TB_PLIC_MODEL_SVH
`define TB_PLIC_MODEL_SVH

// Reference state, stepped once per rising clock edge
src_vec_t                         m_pend;
src_vec_t                         m_insvc;
prio_t    [`PLIC_NUM_SOURCES-1:0] m_prio;
src_vec_t [`PLIC_NUM_TARGETS-1:0] m_en;
prio_t    [`PLIC_NUM_TARGETS-1:0] m_thr;
src_id_t  [`PLIC_NUM_TARGETS-1:0] m_best;
tgt_vec_t                         m_eip;
reg_data_t                        m_rdata;

function automatic reg_addr_t prio_addr(int s);
    return `PLIC_PRIO_BASE + s * `PLIC_PRIO_STRIDE;
endfunction

function automatic reg_addr_t en_addr(int t);
    return `PLIC_ENABLE_BASE + t * `PLIC_ENABLE_STRIDE;
endfunction

function automatic reg_addr_t ctx_addr(int t, reg_addr_t off);
    return `PLIC_CTX_BASE + t * `PLIC_CTX_STRIDE + off;
endfunction

// Highest priority first, lowest ID first within one priority
function automatic src_id_t winner(int t);
    for (int p = (1 << `PLIC_PRIO_WIDTH) - 1; p > 0; p--) begin
        for (int s = 1; s < `PLIC_NUM_SOURCES; s++) begin
            if (m_pend[s] && m_en[t][s] && (m_prio[s] == p)) begin
                return src_id_t'(s);
            end
        end
    end
    return '0;
endfunction

// Value a read returns, from the state before the edge
function automatic reg_data_t read_value(reg_addr_t addr);
    reg_data_t d;
    d = '0;
    for (int s = 0; s < `PLIC_NUM_SOURCES; s++) begin
        if (addr == prio_addr(s)) begin
            d = reg_data_t'(m_prio[s]);
        end
    end
    if (addr == `PLIC_PENDING_ADDR) begin
        d = reg_data_t'(m_pend);
    end
    for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
        if (addr == en_addr(t)) begin
            d = reg_data_t'(m_en[t]);
        end
        if (addr == ctx_addr(t, `PLIC_THRESHOLD_OFFSET)) begin
            d = reg_data_t'(m_thr[t]);
        end
        // A claim of a source that is no longer pending gives 0
        if (addr == ctx_addr(t, `PLIC_CLAIM_OFFSET)) begin
            d = m_pend[m_best[t]] ? reg_data_t'(m_best[t]) : '0;
        end
    end
    return d;
endfunction

task automatic model_reset();
    m_pend  = '0;
    m_insvc = '0;
    m_prio  = '0;
    m_en    = '0;
    m_thr   = '0;
    m_best  = '0;
    m_eip   = '0;
    m_rdata = '0;
endtask

task automatic model_step(input logic req, input logic we, input reg_addr_t addr,
                          input reg_data_t wdata, input src_vec_t src);
    src_vec_t claim_v;
    src_vec_t done_v;
    src_id_t  wid;
    claim_v = '0;
    done_v  = '0;
    wid     = wdata[`PLIC_SRC_ID_WIDTH-1:0];
    for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
        if (req && (addr == ctx_addr(t, `PLIC_CLAIM_OFFSET))) begin
            if (!we) begin
                claim_v[m_best[t]] = m_pend[m_best[t]];
            end else begin
                done_v[wid] = m_insvc[wid];
            end
        end
    end
    if (req && !we) begin
        m_rdata = read_value(addr);
    end
    // Winner and line are registered from the old pending bits
    for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
        m_best[t] = winner(t);
        m_eip[t]  = m_prio[m_best[t]] > m_thr[t];
    end
    // Gateway rules, one source at a time
    for (int s = 1; s < `PLIC_NUM_SOURCES; s++) begin
        if (claim_v[s]) begin
            m_pend[s]  = 1'b0;
            m_insvc[s] = 1'b1;
        end else if (done_v[s]) begin
            // A high source requests again on the next edge
            m_insvc[s] = 1'b0;
        end else if (src[s] && !m_pend[s] && !m_insvc[s]) begin
            m_pend[s] = 1'b1;
        end
    end
    if (req && we) begin
        for (int s = 1; s < `PLIC_NUM_SOURCES; s++) begin
            if (addr == prio_addr(s)) begin
                m_prio[s] = wdata[`PLIC_PRIO_WIDTH-1:0];
            end
        end
        for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
            if (addr == en_addr(t)) begin
                m_en[t] = wdata[`PLIC_NUM_SOURCES-1:0];
            end
            if (addr == ctx_addr(t, `PLIC_THRESHOLD_OFFSET)) begin
                m_thr[t] = wdata[`PLIC_PRIO_WIDTH-1:0];
            end
        end
    end
endtask

`endif

//--- tb_periph_irq_top.sv
`timescale 1ns/100ps

`include "plic_macros.svh"

module tb_periph_irq_top
    import plic_pkg::*;
();

    localparam int CYCLE_LIMIT = 20000;

    logic       clk_i;
    logic       arst_n_i;
    logic       reg_req_i;
    logic       reg_we_i;
    reg_addr_t  reg_addr_i;
    reg_data_t  reg_wdata_i;
    reg_data_t  reg_rdata_o;
    logic       c2h_irq_i;
    logic       cluster_eoc_i;
    logic       irq_mbox_i;
    logic       cl_dma_pe_evt_i;
    logic [3:0] udma_evt_i;
    logic [1:0] can_irq_i;
    logic [3:0] pwm_irq_i;
    tgt_vec_t   irq_o;

    // Source vector as the DUT sees it
    src_vec_t    src_drv;
    int          errors;
    int          checks;
    int          cycles;
    int unsigned seed;
    reg_addr_t   bad_addr [5] = '{32'h0000_0040, 32'h0000_1004, 32'h0000_2100,
                                  32'h0020_0008, 32'h0020_2000};

    `include "tb_plic_model.svh"

    periph_irq_top periph_irq_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            model_reset();
        end else begin
            model_step(reg_req_i, reg_we_i, reg_addr_i, reg_wdata_i, src_drv);
        end
    end

    // ------------------------------
    // Cycle count and line check
    // ------------------------------
    always @(negedge clk_i) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
            $display("checks %0d errors %0d", checks, errors);
            $display("sim failed");
            $finish;
        end else if (arst_n_i) begin
            checks++;
            if (irq_o !== m_eip) begin
                errors++;
                $display("Error %0t irq_o expected %b actual %b", $time, m_eip, irq_o);
            end
        end
    end

    task automatic check_value(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // ------------------------------
    // Bus and event drivers
    // ------------------------------
    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk_i);
        reg_req_i   <= 1'b1;
        reg_we_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk_i);
        reg_req_i <= 1'b0;
    endtask

    // Read data is valid one cycle after the strobe
    task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk_i);
        reg_req_i  <= 1'b1;
        reg_we_i   <= 1'b0;
        reg_addr_i <= addr;
        @(posedge clk_i);
        reg_req_i <= 1'b0;
        @(negedge clk_i);
        data = reg_rdata_o;
    endtask

    task automatic read_check(input reg_addr_t addr, input string name, output reg_data_t d);
        bus_read(addr, d);
        check_value(name, m_rdata, d);
    endtask

    task automatic claim(input int t, output src_id_t id);
        reg_data_t d;
        read_check(ctx_addr(t, `PLIC_CLAIM_OFFSET), "reg_rdata_o claim", d);
        id = d[`PLIC_SRC_ID_WIDTH-1:0];
    endtask

    task automatic complete(input int t, input src_id_t id);
        bus_write(ctx_addr(t, `PLIC_CLAIM_OFFSET), reg_data_t'(id));
    endtask

    task automatic drive_sources(input src_vec_t v);
        @(posedge clk_i);
        src_drv         <= v & 16'h7ffe;
        c2h_irq_i       <= v[1];
        cluster_eoc_i   <= v[2];
        irq_mbox_i      <= v[3];
        udma_evt_i      <= v[7:4];
        cl_dma_pe_evt_i <= v[8];
        can_irq_i       <= v[10:9];
        pwm_irq_i       <= v[14:11];
    endtask

    // Lowers all sources and empties pending and in-service state on target 0
    task automatic drain();
        src_id_t id;
        drive_sources('0);
        for (int s = 1; s < `PLIC_NUM_SOURCES; s++) begin
            bus_write(prio_addr(s), 32'd1);
        end
        bus_write(en_addr(0), 32'h0000_fffe);
        bus_write(ctx_addr(0, `PLIC_THRESHOLD_OFFSET), '0);
        for (int s = 1; s < `PLIC_NUM_SOURCES; s++) begin
            complete(0, src_id_t'(s));
        end
        for (int n = 0; n < `PLIC_NUM_SOURCES; n++) begin
            claim(0, id);
            if (id == '0) break;
            complete(0, id);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        reg_data_t d;
        src_id_t   cid;
        src_id_t   claimed [$];
        int        start;
        int        t;
        seed            = 32'h33f8_49a6;
        seed            = $urandom(seed);
        errors          = 0;
        checks          = 0;
        cycles          = 0;
        arst_n_i        = 1'b0;
        reg_req_i       = 1'b0;
        reg_we_i        = 1'b0;
        reg_addr_i      = '0;
        reg_wdata_i     = '0;
        src_drv         = '0;
        c2h_irq_i       = 1'b0;
        cluster_eoc_i   = 1'b0;
        irq_mbox_i      = 1'b0;
        cl_dma_pe_evt_i = 1'b0;
        udma_evt_i      = '0;
        can_irq_i       = '0;
        pwm_irq_i       = '0;
        repeat (4) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // Register round trip
        for (int s = 0; s < `PLIC_NUM_SOURCES; s++) begin
            bus_write(prio_addr(s), $urandom);
        end
        for (int i = 0; i < `PLIC_NUM_TARGETS; i++) begin
            bus_write(en_addr(i), $urandom);
            bus_write(ctx_addr(i, `PLIC_THRESHOLD_OFFSET), $urandom);
        end
        for (int s = 1; s < `PLIC_NUM_SOURCES; s++) begin
            read_check(prio_addr(s), "reg_rdata_o priority", d);
        end
        for (int i = 0; i < `PLIC_NUM_TARGETS; i++) begin
            read_check(en_addr(i), "reg_rdata_o enable", d);
            read_check(ctx_addr(i, `PLIC_THRESHOLD_OFFSET), "reg_rdata_o threshold", d);
        end
        bus_read(prio_addr(0), d);
        check_value("reg_rdata_o priority 0", '0, d);
        foreach (bad_addr[i]) begin
            bus_read(bad_addr[i], d);
            check_value("reg_rdata_o unmapped", '0, d);
        end
        drive_sources($urandom);
        repeat (3) @(posedge clk_i);
        read_check(`PLIC_PENDING_ADDR, "reg_rdata_o pending", d);
        drain();

        // Source map, one event line at a time
        for (int id = 1; id < `PLIC_NUM_SOURCES - 1; id++) begin
            drive_sources(src_vec_t'(1) << id);
            repeat (3) @(posedge clk_i);
            bus_read(`PLIC_PENDING_ADDR, d);
            check_value("reg_rdata_o pending", 32'd1 << id, d);
            drive_sources('0);
            claim(0, cid);
            check_value("reg_rdata_o claim", id, cid);
            complete(0, cid);
        end

        // Priority and threshold on both targets
        repeat (25) begin
            repeat (4) bus_write(prio_addr($urandom_range(1, 15)), $urandom);
            for (int i = 0; i < `PLIC_NUM_TARGETS; i++) begin
                bus_write(en_addr(i), $urandom);
                bus_write(ctx_addr(i, `PLIC_THRESHOLD_OFFSET), $urandom_range(0, 3));
            end
            drive_sources($urandom);
            repeat (3) @(posedge clk_i);
            for (int i = 0; i < `PLIC_NUM_TARGETS; i++) begin
                claim(i, cid);
                if (cid != '0) complete(i, cid);
            end
        end

        // Claim and complete gating on ID 9
        drain();
        bus_write(en_addr(1), '0);
        drive_sources(src_vec_t'(1) << 9);
        repeat (3) @(posedge clk_i);
        claim(0, cid);
        check_value("reg_rdata_o claim", 32'd9, cid);
        repeat (4) @(posedge clk_i);
        bus_read(`PLIC_PENDING_ADDR, d);
        check_value("reg_rdata_o pending", '0, d);
        complete(0, 4'd3);
        repeat (3) @(posedge clk_i);
        bus_read(`PLIC_PENDING_ADDR, d);
        check_value("reg_rdata_o pending", '0, d);
        complete(0, 4'd9);
        repeat (3) @(posedge clk_i);
        bus_read(`PLIC_PENDING_ADDR, d);
        check_value("reg_rdata_o pending", 32'h0000_0200, d);
        claim(0, cid);
        check_value("reg_rdata_o claim", 32'd9, cid);
        drive_sources('0);
        complete(0, 4'd9);
        repeat (3) @(posedge clk_i);
        claim(0, cid);
        check_value("reg_rdata_o claim", '0, cid);

        // Random run
        start = cycles;
        while (cycles - start < 2000) begin
            case ($urandom_range(0, 4))
                0: drive_sources($urandom);
                1: begin
                    t = $urandom_range(0, 1);
                    claim(t, cid);
                    if (cid != '0) claimed.push_back(cid);
                end
                2: begin
                    if (claimed.size() > 0) begin
                        complete($urandom_range(0, 1), claimed.pop_front());
                    end else begin
                        complete(0, $urandom);
                    end
                end
                3: bus_write(prio_addr($urandom_range(1, 15)), $urandom);
                default: @(posedge clk_i);
            endcase
        end

        repeat (2) @(posedge clk_i);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- periph_irq_top.sv
`timescale 1ns/100ps

`include "plic_macros.svh"

module periph_irq_top
    import plic_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,

    // Register strobe bus
    input  logic       reg_req_i,
    input  logic       reg_we_i,
    input  reg_addr_t  reg_addr_i,
    input  reg_data_t  reg_wdata_i,
    output reg_data_t  reg_rdata_o,

    // SoC event lines, all levels
    input  logic       c2h_irq_i,
    input  logic       cluster_eoc_i,
    input  logic       irq_mbox_i,
    input  logic       cl_dma_pe_evt_i,
    input  logic [3:0] udma_evt_i,
    input  logic [1:0] can_irq_i,
    input  logic [3:0] pwm_irq_i,

    // Bit 0 machine, bit 1 supervisor
    output tgt_vec_t   irq_o
);

    src_vec_t                         irq_sources;
    src_vec_t                         pending;
    src_id_t  [`PLIC_NUM_TARGETS-1:0] best_id;
    prio_t    [`PLIC_NUM_SOURCES-1:0] prio;
    src_vec_t [`PLIC_NUM_TARGETS-1:0] enable;
    prio_t    [`PLIC_NUM_TARGETS-1:0] threshold;
    logic                             claim;
    src_id_t                          claim_id;
    logic                             complete;
    src_id_t                          complete_id;

    // ------------------------------
    // Source map
    // ------------------------------
    assign irq_sources[0]     = 1'b0;
    assign irq_sources[1]     = c2h_irq_i;
    assign irq_sources[2]     = cluster_eoc_i;
    assign irq_sources[3]     = irq_mbox_i;
    assign irq_sources[7:4]   = udma_evt_i;
    assign irq_sources[8]     = cl_dma_pe_evt_i;
    assign irq_sources[10:9]  = can_irq_i;
    assign irq_sources[14:11] = pwm_irq_i;
    // Spare ID
    assign irq_sources[15]    = 1'b0;

    // ------------------------------
    // Interrupt controller
    // ------------------------------
    plic_gateway plic_gateway_inst (
        .clk_i         ( clk_i       ),
        .arst_n_i      ( arst_n_i    ),
        .src_i         ( irq_sources ),
        .claim_i       ( claim       ),
        .claim_id_i    ( claim_id    ),
        .complete_i    ( complete    ),
        .complete_id_i ( complete_id ),
        .pending_o     ( pending     )
    );

    plic_regs plic_regs_inst (
        .clk_i         ( clk_i       ),
        .arst_n_i      ( arst_n_i    ),
        .reg_req_i     ( reg_req_i   ),
        .reg_we_i      ( reg_we_i    ),
        .reg_addr_i    ( reg_addr_i  ),
        .reg_wdata_i   ( reg_wdata_i ),
        .reg_rdata_o   ( reg_rdata_o ),
        .pending_i     ( pending     ),
        .best_id_i     ( best_id     ),
        .prio_o        ( prio        ),
        .enable_o      ( enable      ),
        .threshold_o   ( threshold   ),
        .claim_o       ( claim       ),
        .claim_id_o    ( claim_id    ),
        .complete_o    ( complete    ),
        .complete_id_o ( complete_id )
    );

    plic_target plic_target_inst (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .pending_i   ( pending   ),
        .prio_i      ( prio      ),
        .enable_i    ( enable    ),
        .threshold_i ( threshold ),
        .best_id_o   ( best_id   ),
        .eip_o       ( irq_o     )
    );

endmodule

//--- plic_target.sv
`timescale 1ns/100ps

`include "plic_macros.svh"

module plic_target
    import plic_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             arst_n_i,

    // Pending vector from the gateway
    input  src_vec_t                         pending_i,

    // Configuration from the register block
    input  prio_t    [`PLIC_NUM_SOURCES-1:0] prio_i,
    input  src_vec_t [`PLIC_NUM_TARGETS-1:0] enable_i,
    input  prio_t    [`PLIC_NUM_TARGETS-1:0] threshold_i,

    output src_id_t  [`PLIC_NUM_TARGETS-1:0] best_id_o,
    output tgt_vec_t                         eip_o
);

    src_id_t [`PLIC_NUM_TARGETS-1:0] best_id_d;
    src_id_t [`PLIC_NUM_TARGETS-1:0] best_id_q;
    prio_t   [`PLIC_NUM_TARGETS-1:0] best_prio;
    tgt_vec_t eip_d;
    tgt_vec_t eip_q;

    // ------------------------------
    // Highest priority search
    // ------------------------------

    // Ascending scan with a strict compare, so the lower ID keeps a tie
    always_comb begin
        best_id_d = '0;
        best_prio = '0;
        eip_d     = '0;
        for (int t = 0; t < `PLIC_NUM_TARGETS; t++) begin
            for (int s = 1; s < `PLIC_NUM_SOURCES; s++) begin
                if (pending_i[s] && enable_i[t][s] && (prio_i[s] > best_prio[t])) begin
                    best_prio[t] = prio_i[s];
                    best_id_d[t] = src_id_t'(s);
                end
            end
            // Zero priority never wins, so best_prio 0 means nothing to take
            eip_d[t] = (best_prio[t] > threshold_i[t]);
        end
    end

    // ------------------------------
    // Output registers
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            best_id_q <= '0;
            eip_q     <= '0;
        end else begin
            best_id_q <= best_id_d;
            eip_q     <= eip_d;
        end
    end

    assign best_id_o = best_id_q;
    assign eip_o     = eip_q;

    // Reserved ID 0 is never pending and keeps priority zero
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !pending_i[0] && (prio_i[0] == '0));

endmodule

//--- plic_regs.sv
`timescale 1ns/100ps

`include "plic_macros.svh"

module plic_regs
    import plic_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             arst_n_i,

    // Register strobe bus
    input  logic                             reg_req_i,
    input  logic                             reg_we_i,
    input  reg_addr_t                        reg_addr_i,
    input  reg_data_t                        reg_wdata_i,
    output reg_data_t                        reg_rdata_o,

    // State from gateway and target blocks
    input  src_vec_t                         pending_i,
    input  src_id_t  [`PLIC_NUM_TARGETS-1:0] best_id_i,

    // Configuration towards the target block
    output prio_t    [`PLIC_NUM_SOURCES-1:0] prio_o,
    output src_vec_t [`PLIC_NUM_TARGETS-1:0] enable_o,
    output prio_t    [`PLIC_NUM_TARGETS-1:0] threshold_o,

    // Pulses towards the gateway
    output logic                             claim_o,
    output src_id_t                          claim_id_o,
    output logic                             complete_o,
    output src_id_t                          complete_id_o
);

    localparam int unsigned EN_SHIFT  = $clog2(`PLIC_ENABLE_STRIDE);
    localparam int unsigned CTX_SHIFT = $clog2(`PLIC_CTX_STRIDE);

    prio_t    [`PLIC_NUM_SOURCES-1:0] prio_q;
    src_vec_t [`PLIC_NUM_TARGETS-1:0] enable_q;
    prio_t    [`PLIC_NUM_TARGETS-1:0] threshold_q;
    reg_data_t rdata_q;
    reg_data_t rdata_d;

    reg_addr_t prio_off;
    reg_addr_t en_off;
    reg_addr_t ctx_off;
    reg_addr_t ctx_word;
    logic      prio_hit;
    logic      pend_hit;
    logic      en_hit;
    logic      thr_hit;
    logic      cc_hit;
    src_id_t   prio_idx;
    tgt_idx_t  en_tgt;
    tgt_idx_t  ctx_tgt;
    src_id_t   cc_best;
    logic      rd_strobe;
    logic      wr_strobe;

    assign rd_strobe = reg_req_i & ~reg_we_i;
    assign wr_strobe = reg_req_i & reg_we_i;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign prio_off = reg_addr_i - `PLIC_PRIO_BASE;
    assign en_off   = reg_addr_i - `PLIC_ENABLE_BASE;
    assign ctx_off  = reg_addr_i - `PLIC_CTX_BASE;
    assign ctx_word = ctx_off & (`PLIC_CTX_STRIDE - 1);

    assign prio_idx = prio_off[2 +: `PLIC_SRC_ID_WIDTH];
    assign en_tgt   = en_off[EN_SHIFT +: $bits(tgt_idx_t)];
    assign ctx_tgt  = ctx_off[CTX_SHIFT +: $bits(tgt_idx_t)];

    assign prio_hit = (prio_off < `PLIC_NUM_SOURCES * `PLIC_PRIO_STRIDE)
                    && (prio_off[1:0] == 2'b00);
    assign pend_hit = (reg_addr_i == `PLIC_PENDING_ADDR);
    assign en_hit   = (en_off < `PLIC_NUM_TARGETS * `PLIC_ENABLE_STRIDE)
                    && ((en_off & (`PLIC_ENABLE_STRIDE - 1)) == '0);
    assign thr_hit  = (ctx_off < `PLIC_NUM_TARGETS * `PLIC_CTX_STRIDE)
                    && (ctx_word == `PLIC_THRESHOLD_OFFSET);
    assign cc_hit   = (ctx_off < `PLIC_NUM_TARGETS * `PLIC_CTX_STRIDE)
                    && (ctx_word == `PLIC_CLAIM_OFFSET);

    // ------------------------------
    // Claim and complete pulses
    // ------------------------------

    // Stale best ID (already claimed last cycle) gives no claim
    assign cc_best    = best_id_i[ctx_tgt];
    assign claim_o    = rd_strobe & cc_hit & pending_i[cc_best];
    assign claim_id_o = cc_best;

    assign complete_o    = wr_strobe & cc_hit;
    assign complete_id_o = reg_wdata_i[`PLIC_SRC_ID_WIDTH-1:0];

    // ------------------------------
    // Configuration storage
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prio_q      <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (wr_strobe) begin
            // Priority of ID 0 stays zero
            if (prio_hit && (prio_idx != '0)) begin
                prio_q[prio_idx] <= reg_wdata_i[`PLIC_PRIO_WIDTH-1:0];
            end
            if (en_hit) begin
                enable_q[en_tgt] <= reg_wdata_i[`PLIC_NUM_SOURCES-1:0];
            end
            if (thr_hit) begin
                threshold_q[ctx_tgt] <= reg_wdata_i[`PLIC_PRIO_WIDTH-1:0];
            end
        end
    end

    // ------------------------------
    // Read data
    // ------------------------------
    always_comb begin
        rdata_d = '0;
        if (prio_hit) begin
            rdata_d = reg_data_t'(prio_q[prio_idx]);
        end else if (pend_hit) begin
            rdata_d = reg_data_t'(pending_i);
        end else if (en_hit) begin
            rdata_d = reg_data_t'(enable_q[en_tgt]);
        end else if (thr_hit) begin
            rdata_d = reg_data_t'(threshold_q[ctx_tgt]);
        end else if (cc_hit) begin
            rdata_d = claim_o ? reg_data_t'(cc_best) : '0;
        end
    end

    // Holds the last read value until the next read
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (rd_strobe) begin
            rdata_q <= rdata_d;
        end
    end

    assign reg_rdata_o = rdata_q;
    assign prio_o      = prio_q;
    assign enable_o    = enable_q;
    assign threshold_o = threshold_q;

    // A claim never names the reserved ID 0
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        claim_o |-> (claim_id_o != '0));

endmodule

//--- plic_gateway.sv
`timescale 1ns/100ps

`include "plic_macros.svh"

module plic_gateway
    import plic_pkg::*;
(
    input  logic     clk_i,
    input  logic     arst_n_i,

    // Level inputs, one per source ID
    input  src_vec_t src_i,

    // Claim and complete pulses from the register block
    input  logic     claim_i,
    input  src_id_t  claim_id_i,
    input  logic     complete_i,
    input  src_id_t  complete_id_i,

    output src_vec_t pending_o
);

    // ID 0 is reserved and never takes part
    localparam src_vec_t VALID_MASK = ~src_vec_t'(1);

    src_vec_t pending_q;
    src_vec_t in_service_q;
    src_vec_t claim_vec;
    src_vec_t complete_vec;

    // ------------------------------
    // One-hot decode of the pulses
    // ------------------------------
    always_comb begin
        claim_vec    = '0;
        complete_vec = '0;
        if (claim_i) begin
            claim_vec[claim_id_i] = 1'b1;
        end
        if (complete_i) begin
            complete_vec[complete_id_i] = 1'b1;
        end
        // A complete only counts for a source in service
        complete_vec = complete_vec & in_service_q;
    end

    // ------------------------------
    // Level gateway state
    // ------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            // New request only when idle, claim moves it to in service
            pending_q <= ((pending_q & ~claim_vec)
                         | (src_i & ~pending_q & ~in_service_q)) & VALID_MASK;
            in_service_q <= (in_service_q | claim_vec) & ~complete_vec;
        end
    end

    assign pending_o = pending_q;

    // Register block must never claim a source that is not waiting
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        claim_i |-> pending_q[claim_id_i]);

endmodule

//--- plic_pkg.sv
`include "plic_macros.svh"

package plic_pkg;

    // ------------------------------
    // Interrupt types
    // ------------------------------

    // Source ID, 0 means no interrupt
    typedef logic [`PLIC_SRC_ID_WIDTH-1:0] src_id_t;

    // Priority or threshold
    typedef logic [`PLIC_PRIO_WIDTH-1:0] prio_t;

    // One bit per source ID
    typedef logic [`PLIC_NUM_SOURCES-1:0] src_vec_t;

    // One bit per target
    typedef logic [`PLIC_NUM_TARGETS-1:0] tgt_vec_t;

    // Index of a target
    typedef logic [$clog2(`PLIC_NUM_TARGETS)-1:0] tgt_idx_t;

    // ------------------------------
    // Register bus types
    // ------------------------------

    typedef logic [31:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

endpackage

//--- plic_macros.svh
`ifndef PLIC_MACROS_SVH
`define PLIC_MACROS_SVH

// ------------------------------
// Sizes
// ------------------------------

// Source IDs, ID 0 included and never used
`define PLIC_NUM_SOURCES 16
`define PLIC_SRC_ID_WIDTH 4

// Machine and supervisor context of the core
`define PLIC_NUM_TARGETS 2

// Highest priority is 7
`define PLIC_PRIO_WIDTH 3

// ------------------------------
// Register map
// ------------------------------

// One word per source
`define PLIC_PRIO_BASE 32'h0000_0000
`define PLIC_PRIO_STRIDE 32'h0000_0004

// Pending bits, read only
`define PLIC_PENDING_ADDR 32'h0000_1000

// One enable word per target
`define PLIC_ENABLE_BASE 32'h0000_2000
`define PLIC_ENABLE_STRIDE 32'h0000_0080

// One page per target context
`define PLIC_CTX_BASE 32'h0020_0000
`define PLIC_CTX_STRIDE 32'h0000_1000
`define PLIC_THRESHOLD_OFFSET 32'h0000_0000
`define PLIC_CLAIM_OFFSET 32'h0000_0004

`endif
